/* common/msx_upload_pkg.sv */
`default_nettype none

package msx_upload_pkg;

   localparam int DDR3_AW    = 28;
   localparam int RAM_AW     = 27;
   localparam int SIZE_W     = 27;
   localparam int PAGE_SHIFT = 14;    // 16 KiB pages
   localparam int CNT_W      = 25;
   localparam int N_BLOCKS   = 64;
   localparam int N_LOOKUP   = 16;
   localparam int REC_BYTES  = 16;

   localparam logic [3:0] REC_TAG0    = 4'd0;
   localparam logic [3:0] REC_FLAGS   = 4'd3;  // Fill, ro, mapper
   localparam logic [3:0] REC_TYPE    = 4'd4;
   localparam logic [3:0] REC_SIZE_HI = 4'd5;
   localparam logic [3:0] REC_SIZE_LO = 4'd6;
   localparam logic [3:0] REC_ENTRY0  = 4'd7;  // Four entry/argument pairs

   localparam logic [5:0] CFG_INDEX = 6'd1;

   localparam logic [7:0] TYP_NONE   = 8'd0;
   localparam logic [7:0] TYP_CONFIG = 8'd1;
   localparam logic [7:0] TYP_FDC    = 8'd2;

   localparam logic [1:0] MODE_SKIP   = 2'd0;
   localparam logic [1:0] MODE_REF    = 2'd1;
   localparam logic [1:0] MODE_FILLED = 2'd2;
   localparam logic [1:0] MODE_DEVICE = 2'd3;

   localparam logic [5:0] MAPPER_UNUSED = 6'd63;
   localparam logic [5:0] MAPPER_NONE   = 6'd0;

   localparam logic [1:0] DEV_NONE = 2'd0;
   localparam logic [1:0] DEV_FDC  = 2'd1;

   // Argument byte of one slot entry, meaning depends on the entry mode
   typedef union packed {
      struct packed {
         logic [1:0] pad;
         logic [5:0] src_block;
      } ref_arg;
      struct packed {
         logic [5:0] pad;
         logic [1:0] offset;
      } fill_arg;
   } slot_arg_u;

endpackage

`default_nettype wire

/* src/upload_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module upload_regs (
   input  wire                                clk,
   input  wire                                rst_n,
   input  wire                                ioctl_download,
   input  wire  [15:0]                        ioctl_index,
   input  wire  [msx_upload_pkg::SIZE_W-1:0]  ioctl_addr,
   input  wire  [msx_upload_pkg::DDR3_AW-1:0] ddr3_addr,
   input  wire                                bios_we,
   input  wire  [7:0]                         bios_byte,
   output logic                               load,
   output logic                               cfg_read_en,
   output logic [3:0]                         bios_expander_en,
   output logic [1:0]                         bios_msx_typ
);

   logic                              dl_last;
   logic                              dl_end;
   logic [msx_upload_pkg::SIZE_W-1:0] cfg_size;

   assign dl_end = dl_last & ~ioctl_download & (ioctl_index == 16'(msx_upload_pkg::CFG_INDEX));
   assign cfg_read_en = ddr3_addr < msx_upload_pkg::DDR3_AW'(cfg_size);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         dl_last          <= 1'b0;
         load             <= 1'b0;
         cfg_size         <= '0;
         bios_expander_en <= 4'd0;
         bios_msx_typ     <= 2'd0;
      end else begin
         dl_last <= ioctl_download;
         load    <= dl_end;
         if (dl_end) cfg_size <= ioctl_addr;  // Image size in bytes
         if (bios_we) begin
            bios_expander_en <= bios_byte[3:0];
            bios_msx_typ     <= bios_byte[5:4];
         end
      end
   end

   assert property (@(posedge clk) disable iff (!rst_n) load |=> !load);

endmodule

`default_nettype wire

/* loader/loader_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module loader_fsm (
   input  wire                                 clk,
   input  wire                                 rst_n,
   input  wire                                 load,
   input  wire                                 cfg_read_en,
   input  wire  [7:0]                          ddr3_dout,
   input  wire                                 ddr3_ready,
   output logic [msx_upload_pkg::DDR3_AW-1:0]  ddr3_addr,
   output logic                                ddr3_rd,
   output logic                                ddr3_request,
   output logic                                reset_rq,
   input  wire                                 fill_done,
   input  wire                                 fill_rd,
   output logic                                fill_start,
   output logic                                copy_mode,
   output logic [msx_upload_pkg::CNT_W-1:0]    fill_count,
   output logic                                bios_we,
   output logic [7:0]                          bios_byte,
   output logic                                table_clear,
   output logic [5:0]                          clear_block,
   output logic                                rec_we,
   output logic [7:0]                          rec_bytes [3:14],
   output logic [3:0]                          ref_ram
);

   typedef enum logic [2:0] {S_IDLE, S_CLEAN, S_READ_CONF, S_CHECK, S_FILL, S_STORE} state_t;

   state_t     state;
   logic [7:0] rec [msx_upload_pkg::REC_BYTES];
   logic [3:0] head;
   logic       gate;
   logic       tag_ok;
   logic       typ_slot;
   logic       typ_cfg;

   assign gate     = ddr3_ready & ~ddr3_rd;  // DDR3 idle, data valid
   assign tag_ok   = {rec[msx_upload_pkg::REC_TAG0], rec[msx_upload_pkg::REC_TAG0 + 1],
                      rec[msx_upload_pkg::REC_TAG0 + 2]} == "MSX";
   assign typ_slot = rec[msx_upload_pkg::REC_TYPE] == msx_upload_pkg::TYP_NONE ||
                     rec[msx_upload_pkg::REC_TYPE] == msx_upload_pkg::TYP_FDC;
   assign typ_cfg  = rec[msx_upload_pkg::REC_TYPE] == msx_upload_pkg::TYP_CONFIG;

   assign reset_rq    = state != S_IDLE;
   assign table_clear = gate && state == S_CLEAN;
   assign fill_start  = gate && state == S_FILL;
   assign rec_we      = gate && state == S_STORE && typ_slot;
   assign bios_we     = gate && state == S_STORE && typ_cfg;
   assign bios_byte   = rec[msx_upload_pkg::REC_SIZE_HI];

   always_comb begin
      for (int i = 3; i <= 14; i++) rec_bytes[i] = rec[i];
   end

   always_ff @(posedge clk) begin
      if (gate && state == S_READ_CONF) rec[head] <= ddr3_dout;
      if (gate && state == S_CHECK) begin
         copy_mode  <= rec[msx_upload_pkg::REC_FLAGS][6];  // Read-only data comes from DDR3
         fill_count <= (msx_upload_pkg::CNT_W'({rec[msx_upload_pkg::REC_SIZE_HI][2:0],
                        rec[msx_upload_pkg::REC_SIZE_LO]}) << msx_upload_pkg::PAGE_SHIFT) - 1'b1;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state        <= S_IDLE;
         ddr3_addr    <= '0;
         ddr3_rd      <= 1'b0;
         ddr3_request <= 1'b0;
         clear_block  <= 6'd0;
         head         <= 4'd0;
         ref_ram      <= 4'd0;
      end else begin
         if (ddr3_rd && ddr3_ready) begin
            ddr3_rd   <= 1'b0;
            ddr3_addr <= ddr3_addr + 1'b1;
         end
         if (fill_rd) ddr3_rd <= cfg_read_en;  // Next copy byte
         if (gate) begin
            case (state)
               S_IDLE: ddr3_request <= 1'b0;
               S_CLEAN: begin
                  ddr3_request <= 1'b1;
                  clear_block  <= clear_block + 1'b1;
                  if (clear_block == 6'd63) begin
                     state   <= S_READ_CONF;
                     ddr3_rd <= cfg_read_en;
                  end
               end
               S_READ_CONF: begin
                  head <= head + 1'b1;
                  if (head == 4'd15) begin
                     state <= S_CHECK;
                  end else begin
                     ddr3_rd <= cfg_read_en;
                  end
               end
               S_CHECK: begin
                  state <= S_IDLE;
                  if (tag_ok) begin
                     ddr3_rd <= cfg_read_en;  // Prefetch
                     state   <= rec[msx_upload_pkg::REC_FLAGS][7] ? S_FILL : S_STORE;
                  end
               end
               S_STORE: begin
                  state <= S_READ_CONF;
                  if (typ_slot) ref_ram <= ref_ram + 1'b1;
                  if (!(typ_slot || typ_cfg) || !cfg_read_en) state <= S_IDLE;
               end
               default: ;
            endcase
         end
         if (state == S_FILL && fill_done) state <= S_STORE;
         if (load) begin
            state       <= S_CLEAN;
            ddr3_addr   <= '0;
            ddr3_rd     <= 1'b0;
            clear_block <= 6'd0;
            head        <= 4'd0;
            ref_ram     <= 4'd0;
         end
      end
   end

   assert property (@(posedge clk) disable iff (!rst_n) state == S_IDLE |-> !ddr3_rd);

endmodule

`default_nettype wire

/* loader/ram_writer.sv */
`timescale 1ns/1ps
`default_nettype none

module ram_writer (
   input  wire                                clk,
   input  wire                                rst_n,
   input  wire                                fill_start,
   input  wire                                copy_mode,
   input  wire  [msx_upload_pkg::CNT_W-1:0]   fill_count,
   input  wire  [7:0]                         ddr3_dout,
   input  wire                                sdram_ready,
   output logic [msx_upload_pkg::RAM_AW-1:0]  ram_addr,
   output logic [7:0]                         ram_din,
   output logic                               ram_ce,
   output logic                               sdram_rq,
   output logic                               fill_done,
   output logic                               fill_rd,
   output logic [msx_upload_pkg::RAM_AW-1:0]  fill_addr
);

   logic                             busy;
   logic                             step;
   logic [msx_upload_pkg::CNT_W-1:0] cnt;
   logic [msx_upload_pkg::CNT_W-1:0] remain;

   assign step    = fill_start & sdram_ready & ~ram_ce;
   assign remain  = busy ? cnt : fill_count;  // Bytes left minus one
   assign fill_rd = step & copy_mode;
   // Checkerboard RAM pattern
   assign ram_din = copy_mode ? ddr3_dout : (ram_addr[8] == ram_addr[1] ? 8'hFF : 8'h00);

   always_ff @(posedge clk) begin
      if (step) cnt <= remain - 1'b1;
      if (step && !busy) fill_addr <= ram_addr;  // Start of this fill
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         ram_addr  <= '0;
         ram_ce    <= 1'b0;
         sdram_rq  <= 1'b0;
         busy      <= 1'b0;
         fill_done <= 1'b0;
      end else begin
         ram_ce    <= step;
         fill_done <= step && remain == '0;
         if (ram_ce) ram_addr <= ram_addr + 1'b1;
         if (step) busy <= remain != '0;
         if (fill_start) sdram_rq <= 1'b1;
         if (fill_done) sdram_rq <= 1'b0;
      end
   end

   assert property (@(posedge clk) disable iff (!rst_n) ram_ce |=> !ram_ce);

endmodule

`default_nettype wire

/* src/slot_table.sv */
`timescale 1ns/1ps
`default_nettype none

module slot_table (
   input  wire                                clk,
   input  wire                                rst_n,
   input  wire                                table_clear,
   input  wire  [5:0]                         clear_block,
   input  wire                                rec_we,
   input  wire  [7:0]                         rec_bytes [3:14],
   input  wire  [3:0]                         ref_ram,
   input  wire  [msx_upload_pkg::RAM_AW-1:0]  fill_addr,
   output logic [5:0]                         slot_mapper  [msx_upload_pkg::N_BLOCKS],
   output logic [1:0]                         slot_device  [msx_upload_pkg::N_BLOCKS],
   output logic [3:0]                         slot_ref_ram [msx_upload_pkg::N_BLOCKS],
   output logic [1:0]                         slot_offset  [msx_upload_pkg::N_BLOCKS],
   output logic [msx_upload_pkg::RAM_AW-1:0]  lookup_addr  [msx_upload_pkg::N_LOOKUP],
   output logic [15:0]                        lookup_size  [msx_upload_pkg::N_LOOKUP],
   output logic                               lookup_ro    [msx_upload_pkg::N_LOOKUP]
);

   logic [1:0] rec_dev;
   logic [5:0] rec_mapper;

   assign rec_dev    = rec_bytes[msx_upload_pkg::REC_TYPE] == msx_upload_pkg::TYP_FDC ?
                       msx_upload_pkg::DEV_FDC : msx_upload_pkg::DEV_NONE;
   // A filled block must never look unused
   assign rec_mapper = rec_bytes[msx_upload_pkg::REC_FLAGS][5:0] == msx_upload_pkg::MAPPER_UNUSED ?
                       msx_upload_pkg::MAPPER_NONE : rec_bytes[msx_upload_pkg::REC_FLAGS][5:0];

   always_ff @(posedge clk or negedge rst_n) begin : upd
      logic [5:0]                blk;
      logic [1:0]                mode;
      msx_upload_pkg::slot_arg_u arg;
      if (!rst_n) begin
         for (int b = 0; b < msx_upload_pkg::N_BLOCKS; b++) begin
            slot_mapper[b] <= msx_upload_pkg::MAPPER_UNUSED;
            slot_device[b] <= msx_upload_pkg::DEV_NONE;
         end
      end else if (table_clear) begin
         slot_mapper[clear_block] <= msx_upload_pkg::MAPPER_UNUSED;
         slot_device[clear_block] <= msx_upload_pkg::DEV_NONE;
      end else if (rec_we) begin
         if (rec_bytes[msx_upload_pkg::REC_FLAGS][7]) begin
            lookup_addr[ref_ram] <= fill_addr;
            lookup_size[ref_ram] <= {rec_bytes[msx_upload_pkg::REC_SIZE_HI],
                                     rec_bytes[msx_upload_pkg::REC_SIZE_LO]};
            lookup_ro[ref_ram]   <= rec_bytes[msx_upload_pkg::REC_FLAGS][6];
         end
         for (int e = 0; e < 4; e++) begin
            blk  = rec_bytes[msx_upload_pkg::REC_ENTRY0 + 2 * e][5:0];
            mode = rec_bytes[msx_upload_pkg::REC_ENTRY0 + 2 * e][7:6];
            arg  = rec_bytes[msx_upload_pkg::REC_ENTRY0 + 2 * e + 1];
            case (mode)
               msx_upload_pkg::MODE_SKIP: ;
               msx_upload_pkg::MODE_REF: begin  // Old value of source block
                  slot_ref_ram[blk] <= slot_ref_ram[arg.ref_arg.src_block];
                  slot_offset[blk]  <= slot_offset[arg.ref_arg.src_block];
                  slot_mapper[blk]  <= slot_mapper[arg.ref_arg.src_block];
                  slot_device[blk]  <= rec_dev;
               end
               msx_upload_pkg::MODE_FILLED: begin
                  slot_ref_ram[blk] <= ref_ram;
                  slot_offset[blk]  <= arg.fill_arg.offset;
                  slot_mapper[blk]  <= rec_mapper;
                  slot_device[blk]  <= rec_dev;
               end
               msx_upload_pkg::MODE_DEVICE: slot_device[blk] <= rec_dev;
            endcase
         end
      end
   end

endmodule

`default_nettype wire

/* src/msx_upload_top.sv */
`timescale 1ns/1ps
`default_nettype none

module msx_upload_top (
   input  wire                                clk,
   input  wire                                rst_n,
   input  wire                                ioctl_download,
   input  wire  [15:0]                        ioctl_index,
   input  wire  [msx_upload_pkg::SIZE_W-1:0]  ioctl_addr,
   output wire  [msx_upload_pkg::DDR3_AW-1:0] ddr3_addr,
   output wire                                ddr3_rd,
   input  wire  [7:0]                         ddr3_dout,
   input  wire                                ddr3_ready,
   output wire                                ddr3_request,
   output wire  [msx_upload_pkg::RAM_AW-1:0]  ram_addr,
   output wire  [7:0]                         ram_din,
   output wire                                ram_ce,
   input  wire                                sdram_ready,
   output wire                                sdram_rq,
   output wire                                reset_rq,
   output logic [5:0]                         slot_mapper  [msx_upload_pkg::N_BLOCKS],
   output logic [1:0]                         slot_device  [msx_upload_pkg::N_BLOCKS],
   output logic [3:0]                         slot_ref_ram [msx_upload_pkg::N_BLOCKS],
   output logic [1:0]                         slot_offset  [msx_upload_pkg::N_BLOCKS],
   output logic [msx_upload_pkg::RAM_AW-1:0]  lookup_addr  [msx_upload_pkg::N_LOOKUP],
   output logic [15:0]                        lookup_size  [msx_upload_pkg::N_LOOKUP],
   output logic                               lookup_ro    [msx_upload_pkg::N_LOOKUP],
   output wire  [3:0]                         bios_expander_en,
   output wire  [1:0]                         bios_msx_typ
);

   wire                                load;
   wire                                cfg_read_en;
   wire                                fill_start;
   wire                                copy_mode;
   wire [msx_upload_pkg::CNT_W-1:0]    fill_count;
   wire                                fill_done;
   wire                                fill_rd;
   wire [msx_upload_pkg::RAM_AW-1:0]   fill_addr;
   wire                                bios_we;
   wire [7:0]                          bios_byte;
   wire                                table_clear;
   wire [5:0]                          clear_block;
   wire                                rec_we;
   logic [7:0]                         rec_bytes [3:14];
   wire [3:0]                          ref_ram;

   upload_regs u_regs (
      .clk(clk), .rst_n(rst_n),
      .ioctl_download(ioctl_download), .ioctl_index(ioctl_index), .ioctl_addr(ioctl_addr),
      .ddr3_addr(ddr3_addr), .bios_we(bios_we), .bios_byte(bios_byte),
      .load(load), .cfg_read_en(cfg_read_en),
      .bios_expander_en(bios_expander_en), .bios_msx_typ(bios_msx_typ)
   );

   loader_fsm u_fsm (
      .clk(clk), .rst_n(rst_n), .load(load), .cfg_read_en(cfg_read_en),
      .ddr3_dout(ddr3_dout), .ddr3_ready(ddr3_ready), .ddr3_addr(ddr3_addr),
      .ddr3_rd(ddr3_rd), .ddr3_request(ddr3_request), .reset_rq(reset_rq),
      .fill_done(fill_done), .fill_rd(fill_rd), .fill_start(fill_start),
      .copy_mode(copy_mode), .fill_count(fill_count),
      .bios_we(bios_we), .bios_byte(bios_byte),
      .table_clear(table_clear), .clear_block(clear_block),
      .rec_we(rec_we), .rec_bytes(rec_bytes), .ref_ram(ref_ram)
   );

   ram_writer u_writer (
      .clk(clk), .rst_n(rst_n), .fill_start(fill_start), .copy_mode(copy_mode),
      .fill_count(fill_count), .ddr3_dout(ddr3_dout), .sdram_ready(sdram_ready),
      .ram_addr(ram_addr), .ram_din(ram_din), .ram_ce(ram_ce), .sdram_rq(sdram_rq),
      .fill_done(fill_done), .fill_rd(fill_rd), .fill_addr(fill_addr)
   );

   slot_table u_table (
      .clk(clk), .rst_n(rst_n), .table_clear(table_clear), .clear_block(clear_block),
      .rec_we(rec_we), .rec_bytes(rec_bytes), .ref_ram(ref_ram), .fill_addr(fill_addr),
      .slot_mapper(slot_mapper), .slot_device(slot_device),
      .slot_ref_ram(slot_ref_ram), .slot_offset(slot_offset),
      .lookup_addr(lookup_addr), .lookup_size(lookup_size), .lookup_ro(lookup_ro)
   );

endmodule

`default_nettype wire

/* dv/tb_clock.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
   output logic clk,
   output logic rst_n
);

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;  // 10 ns period
   end

   initial begin
      rst_n = 1'b0;
      repeat (3) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
   end

endmodule

`default_nettype wire

/* dv/tb_msx_upload.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_msx_upload;

   localparam int PAGE     = 16384;
   localparam int IMG_SIZE = 16464;
   localparam int WD_CYCLES = 4 * PAGE * 8 + 20000;  // Two runs of two pages each

   wire         clk;
   wire         rst_n;
   logic        ioctl_download;
   logic [15:0] ioctl_index;
   logic [26:0] ioctl_addr;
   wire  [27:0] ddr3_addr;
   wire         ddr3_rd;
   logic [7:0]  ddr3_dout;
   logic        ddr3_ready;
   wire         ddr3_request;
   wire  [26:0] ram_addr;
   wire  [7:0]  ram_din;
   wire         ram_ce;
   logic        sdram_ready;
   wire         sdram_rq;
   wire         reset_rq;
   logic [5:0]  slot_mapper  [64];
   logic [1:0]  slot_device  [64];
   logic [3:0]  slot_ref_ram [64];
   logic [1:0]  slot_offset  [64];
   logic [26:0] lookup_addr  [16];
   logic [15:0] lookup_size  [16];
   logic        lookup_ro    [16];
   wire  [3:0]  bios_expander_en;
   wire  [1:0]  bios_msx_typ;

   logic [7:0]  ddr_mem [IMG_SIZE];
   logic [31:0] rng;
   logic        pending;
   int          lat;
   int          wait_cnt;
   int          stall_cnt;
   int          writes;
   int          errors;
   logic [5:0]  exp_mapper [64];
   logic [1:0]  exp_dev    [64];
   logic [3:0]  exp_ref    [64];
   logic [1:0]  exp_off    [64];
   logic        exp_chk    [64];

   tb_clock u_clock (.clk(clk), .rst_n(rst_n));

   msx_upload_top u_dut (
      .clk(clk), .rst_n(rst_n), .ioctl_download(ioctl_download), .ioctl_index(ioctl_index),
      .ioctl_addr(ioctl_addr), .ddr3_addr(ddr3_addr), .ddr3_rd(ddr3_rd),
      .ddr3_dout(ddr3_dout), .ddr3_ready(ddr3_ready), .ddr3_request(ddr3_request),
      .ram_addr(ram_addr), .ram_din(ram_din), .ram_ce(ram_ce), .sdram_ready(sdram_ready),
      .sdram_rq(sdram_rq), .reset_rq(reset_rq), .slot_mapper(slot_mapper),
      .slot_device(slot_device), .slot_ref_ram(slot_ref_ram), .slot_offset(slot_offset),
      .lookup_addr(lookup_addr), .lookup_size(lookup_size), .lookup_ro(lookup_ro),
      .bios_expander_en(bios_expander_en), .bios_msx_typ(bios_msx_typ)
   );

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1103515245 + 32'd12345;
   endfunction

   function automatic logic [7:0] payload_byte(input int a);
      return 8'(a ^ (a >> 7) ^ 32'h3C);
   endfunction

   function automatic logic [7:0] checker_byte(input logic [26:0] a);
      return (a[8] == a[1]) ? 8'hFF : 8'h00;
   endfunction

   task automatic stop_run(input string msg);
      $display("%s", msg);
      $display("Result: FAILED");
      $fatal(1);
   endtask

   task automatic fail_value(input string name, input logic [31:0] got, input logic [31:0] exp);
      errors++;
      $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
      stop_run("Value mismatch");
   endtask

   task automatic put_rec(input int base, input logic [127:0] r);
      for (int i = 0; i < 16; i++) ddr_mem[base + i] = r[8 * (15 - i) +: 8];
   endtask

   task automatic set_block(input int b, input logic [5:0] m, input logic [1:0] d,
                            input logic [3:0] r, input logic [1:0] o);
      exp_mapper[b] = m;
      exp_dev[b]    = d;
      exp_ref[b]    = r;
      exp_off[b]    = o;
      exp_chk[b]    = 1'b1;
   endtask

   task automatic download(input logic [15:0] idx);
      ioctl_index    = idx;
      ioctl_addr     = 27'(IMG_SIZE);
      ioctl_download = 1'b1;
      repeat (4) @(negedge clk);
      ioctl_download = 1'b0;
      @(negedge clk);
   endtask

   task automatic wait_for_run;
      while (!reset_rq) @(negedge clk);
      while (reset_rq) @(negedge clk);
   endtask

   // DDR3 byte model and SDRAM stalls
   always @(negedge clk) begin
      if (rst_n) begin
         rng = lcg_next(rng);
         if (pending) begin
            if (!ddr3_rd) begin
               ddr3_dout = ddr_mem[lat];
               pending   = 1'b0;
            end else if (wait_cnt > 0) begin
               wait_cnt--;
               if (wait_cnt == 0) ddr3_ready = 1'b1;
            end
         end else if (ddr3_rd) begin
            lat = int'(ddr3_addr);
            if (lat >= IMG_SIZE) stop_run("DDR3 read past the end of the image");
            if (!ddr3_request) stop_run("DDR3 read issued without ddr3_request");
            pending    = 1'b1;
            wait_cnt   = int'(rng[17:16]);
            ddr3_ready = (wait_cnt == 0);
         end
         if (stall_cnt > 0) begin
            sdram_ready = 1'b0;
            stall_cnt--;
         end else begin
            sdram_ready = 1'b1;
            if (rng[21:20] == 2'd0) stall_cnt = int'(rng[25:24]);
         end
      end
   end

   // Each run copies one page from DDR3, then writes one checkerboard page
   always @(negedge clk) begin
      if (rst_n && ram_ce) begin
         assert (writes < 4 * PAGE) else stop_run("More SDRAM writes than pages allow");
         assert (sdram_rq) else stop_run("SDRAM write issued without sdram_rq");
         assert (ram_addr == 27'(writes)) else fail_value("ram_addr", 32'(ram_addr), writes);
         if (writes % (2 * PAGE) < PAGE) begin
            assert (ram_din == payload_byte(16 + writes % (2 * PAGE)))
               else fail_value("ram_din", ram_din, payload_byte(16 + writes % (2 * PAGE)));
         end else begin
            assert (ram_din == checker_byte(27'(writes)))
               else fail_value("ram_din", ram_din, checker_byte(27'(writes)));
         end
         writes++;
      end
   end

   initial begin
      repeat (WD_CYCLES) @(posedge clk);
      stop_run("Watchdog timeout, the loader did not finish");
   end

   initial begin
      ioctl_download = 1'b0;
      ioctl_index    = 16'd0;
      ioctl_addr     = '0;
      ddr3_dout      = 8'h00;
      ddr3_ready     = 1'b1;
      sdram_ready    = 1'b1;
      rng            = 32'd17269;
      pending        = 1'b0;
      stall_cnt      = 0;
      writes         = 0;
      errors         = 0;
      for (int a = 16; a < 16 + PAGE; a++) ddr_mem[a] = payload_byte(a);
      put_rec(0, {"MSX", 8'hC5, 8'h00, 8'h00, 8'h01, 8'h8A, 8'h02, 8'h8B, 8'h01, 40'h0});
      put_rec(16400, {"MSX", 8'hBF, 8'h02, 8'h00, 8'h01, 8'h94, 8'h03, 8'h55, 8'h0A,
                      8'hD6, 8'h00, 8'h4A, 8'h0B, 8'h00});
      put_rec(16416, {"MSX", 8'h00, 8'h01, 8'h2B, 8'h00, 72'h0});
      put_rec(16432, {"MSX", 8'h00, 8'h00, 8'h00, 8'h00, 8'h9E, 8'h01, 56'h0});
      put_rec(16448, {"MSX", 8'h00, 8'h02, 8'h00, 8'h00, 8'hDF, 8'h00, 56'h0});
      for (int b = 0; b < 64; b++) set_block(b, 6'd63, 2'd0, 4'd0, 2'd0);
      for (int b = 0; b < 64; b++) exp_chk[b] = 1'b0;
      set_block(10, 6'd5, 2'd1, 4'd0, 2'd1);  // Copied from old block 11
      set_block(11, 6'd5, 2'd0, 4'd0, 2'd1);
      set_block(20, 6'd0, 2'd1, 4'd1, 2'd3);
      set_block(21, 6'd5, 2'd1, 4'd0, 2'd2);  // Copied from old block 10
      exp_dev[22] = 2'd1;

      @(posedge rst_n);
      repeat (2) @(negedge clk);
      assert (!reset_rq && !ddr3_rd && !ddr3_request && !ram_ce && !sdram_rq)
         else stop_run("Outputs not idle after reset");
      download(16'd3);
      repeat (10) @(negedge clk);
      assert (!reset_rq) else fail_value("reset_rq", reset_rq, 0);

      // First run applies records 3 and 4, so blocks 30 and 31 end up in use
      download(16'd1);
      wait_for_run();
      assert (writes == 2 * PAGE) else fail_value("write count", writes, 2 * PAGE);
      assert (ddr3_addr == 28'(IMG_SIZE)) else fail_value("ddr3_addr", ddr3_addr, IMG_SIZE);
      assert (slot_mapper[30] == 6'd0) else fail_value("slot_mapper[30]", slot_mapper[30], 0);
      assert (slot_device[31] == 2'd1) else fail_value("slot_device[31]", slot_device[31], 1);

      // Second run stops at the broken tag of record 3
      ddr_mem[16434] = "Y";
      download(16'd1);
      wait_for_run();
      assert (writes == 4 * PAGE) else fail_value("write count", writes, 4 * PAGE);
      repeat (5) @(negedge clk);
      assert (!reset_rq) else fail_value("reset_rq", reset_rq, 0);
      assert (!ddr3_request) else fail_value("ddr3_request", ddr3_request, 0);
      assert (!sdram_rq) else fail_value("sdram_rq", sdram_rq, 0);
      assert (ddr3_addr == 28'd16448) else fail_value("ddr3_addr", ddr3_addr, 16448);
      assert (bios_expander_en == 4'hB)
         else fail_value("bios_expander_en", bios_expander_en, 4'hB);
      assert (bios_msx_typ == 2'd2) else fail_value("bios_msx_typ", bios_msx_typ, 2);
      assert (lookup_addr[0] == 27'(2 * PAGE))
         else fail_value("lookup_addr[0]", lookup_addr[0], 2 * PAGE);
      assert (lookup_size[0] == 16'd1) else fail_value("lookup_size[0]", lookup_size[0], 1);
      assert (lookup_ro[0] == 1'b1) else fail_value("lookup_ro[0]", lookup_ro[0], 1);
      assert (lookup_addr[1] == 27'(3 * PAGE))
         else fail_value("lookup_addr[1]", lookup_addr[1], 3 * PAGE);
      assert (lookup_size[1] == 16'd1) else fail_value("lookup_size[1]", lookup_size[1], 1);
      assert (lookup_ro[1] == 1'b0) else fail_value("lookup_ro[1]", lookup_ro[1], 0);
      for (int b = 0; b < 64; b++) begin
         assert (slot_mapper[b] == exp_mapper[b])
            else fail_value($sformatf("slot_mapper[%0d]", b), slot_mapper[b], exp_mapper[b]);
         assert (slot_device[b] == exp_dev[b])
            else fail_value($sformatf("slot_device[%0d]", b), slot_device[b], exp_dev[b]);
         if (exp_chk[b]) begin
            assert (slot_ref_ram[b] == exp_ref[b])
               else fail_value($sformatf("slot_ref_ram[%0d]", b), slot_ref_ram[b], exp_ref[b]);
            assert (slot_offset[b] == exp_off[b])
               else fail_value($sformatf("slot_offset[%0d]", b), slot_offset[b], exp_off[b]);
         end
      end
      if (errors == 0) begin
         $display("Result: PASSED");
         $finish;
      end else begin
         stop_run("Errors were recorded");
      end
   end

endmodule

`default_nettype wire

/* src.f */
common/msx_upload_pkg.sv
src/upload_regs.sv
loader/loader_fsm.sv
loader/ram_writer.sv
src/slot_table.sv
src/msx_upload_top.sv
dv/tb_clock.sv
dv/tb_msx_upload.sv

/* run.sh */
#!/bin/sh
# Build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module tb_msx_upload -o sim_msx \
   > build.log 2>&1
if [ $? -ne 0 ]; then
   cat build.log
   echo "Build failed"
   exit 1
fi

./obj_dir/sim_msx > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
   echo "Simulation returned status $sim_status"
   exit 1
fi

if grep -q "^Result: PASSED$" sim.log; then
   exit 0
fi
echo "Pass line not found in sim.log"
exit 1
